/* hdl/conv_pkg.sv */
// Shared widths, types and stream payloads of the 1x1 expand engine

`default_nettype none

package conv_pkg;

	//////////////////////////////////////////////////
	// Datapath widths
	//////////////////////////////////////////////////
	localparam int ACT_W     = 16;
	localparam int WGT_W     = 16;
	localparam int ACC_W     = 40;
	localparam int BIAS_W    = 32;
	localparam int RES_W     = 16;
	localparam int PIX_W     = 16;

	// Fraction bits dropped after the bias add
	localparam int FRAC_BITS = 14;
	localparam int OUT_MAX   = 32767;

	// Lane count of the output payload
	localparam int CHOUT_MAX = 8;

	//////////////////////////////////////////////////
	// Scalar types
	//////////////////////////////////////////////////
	typedef logic signed [ACT_W-1:0]  act_t;
	typedef logic signed [WGT_W-1:0]  wgt_t;
	typedef logic signed [ACC_W-1:0]  acc_t;
	// Bias sits on the product scale
	typedef logic signed [BIAS_W-1:0] bias_t;
	// Always within 0 to OUT_MAX
	typedef logic [RES_W-1:0]         res_t;
	typedef logic [PIX_W-1:0]         pix_t;

	//////////////////////////////////////////////////
	// Stream payloads
	//////////////////////////////////////////////////
	typedef struct packed {
		act_t act;
		logic last;
	} in_beat_t;

	typedef struct packed {
		res_t [CHOUT_MAX-1:0] res;
		pix_t                 pix_idx;
	} out_beat_t;

	// Controller FSM
	typedef enum logic [1:0] {IDLE, RUN, DRAIN} ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/coef_rom.sv */
// Two-bank weight and bias ROM built from the fixed coefficient rule

`timescale 1ns/1ns
`default_nettype none

module coef_rom #(
	parameter int CHIN  = 16,
	parameter int CHOUT = 8
) (
	input  wire                            bank,
	input  wire [$clog2(CHIN)-1:0]         chan_idx,
	output conv_pkg::wgt_t  [CHOUT-1:0]    wgt,
	output conv_pkg::bias_t [CHOUT-1:0]    bias
);

	// Weight code in -16..15, scaled by 256
	function automatic conv_pkg::wgt_t wgt_rule(input int layer, input int k, input int c);
		int code;
		code = ((5 * k + 3 * c + 11 * layer) % 32) - 16;
		return conv_pkg::wgt_t'(code * 256);
	endfunction

	// Bias on the product scale of 2^15
	function automatic conv_pkg::bias_t bias_rule(input int layer, input int k);
		int code;
		code = (k % 8) - 4 + 2 * layer;
		return conv_pkg::bias_t'(code * 32768);
	endfunction

	conv_pkg::wgt_t  wgt_mem  [2][CHIN][CHOUT];
	conv_pkg::bias_t bias_mem [2][CHOUT];

	//////////////////////////////////////////////////
	// Table contents, fixed at elaboration
	//////////////////////////////////////////////////
	for (genvar l = 0; l < 2; l++) begin : g_layer
		for (genvar k = 0; k < CHOUT; k++) begin : g_out
			assign bias_mem[l][k] = bias_rule(l, k);
			for (genvar c = 0; c < CHIN; c++) begin : g_chan
				assign wgt_mem[l][c][k] = wgt_rule(l, k, c);
			end
		end
	end

	// One input channel row across all output lanes
	always_comb begin
		for (int k = 0; k < CHOUT; k++) begin
			wgt[k]  = wgt_mem[bank][chan_idx][k];
			bias[k] = bias_mem[bank][k];
		end
	end

endmodule

`default_nettype wire

/* hdl/mac_array.sv */
// Parallel signed multiply-accumulate lanes, one per output channel

`timescale 1ns/1ns
`default_nettype none

module mac_array #(
	parameter int CHOUT = 8
) (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           acc_en,
	input  wire                           acc_load,
	input  wire conv_pkg::act_t           act,
	input  wire conv_pkg::wgt_t [CHOUT-1:0] wgt,
	output conv_pkg::acc_t [CHOUT-1:0]    acc
);

	conv_pkg::acc_t [CHOUT-1:0] prod;

	//////////////////////////////////////////////////
	// Multipliers
	//////////////////////////////////////////////////

	// Activation is broadcast to every lane
	always_comb begin
		for (int k = 0; k < CHOUT; k++) begin
			prod[k] = conv_pkg::acc_t'($signed(act)) * conv_pkg::acc_t'($signed(wgt[k]));
		end
	end

	//////////////////////////////////////////////////
	// Accumulators
	//////////////////////////////////////////////////

	// First channel of a pixel overwrites the old sum
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			acc <= '0;
		end else if (acc_en) begin
			for (int k = 0; k < CHOUT; k++) begin
				if (acc_load) begin
					acc[k] <= prod[k];
				end else begin
					acc[k] <= acc[k] + prod[k];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/requant_relu.sv */
// Output stage adding bias, applying ReLU, shifting and saturating into a stream register

`timescale 1ns/1ns
`default_nettype none

module requant_relu #(
	parameter int CHOUT = 8
) (
	input  wire                              clk,
	input  wire                              rst,
	input  wire                              cap_en,
	input  wire                              bank,
	input  wire conv_pkg::acc_t  [CHOUT-1:0] acc,
	input  wire conv_pkg::bias_t [CHOUT-1:0] bias,
	input  wire conv_pkg::pix_t              pix_idx,
	input  wire                              out_ready,
	output logic                             out_valid,
	output conv_pkg::out_beat_t              out_data,
	output logic                             slot_free
);

	conv_pkg::bias_t [CHOUT-1:0]              bias_q;
	logic                                     bias_held;
	logic                                     bias_bank;
	logic                                     bias_stale;
	conv_pkg::res_t [conv_pkg::CHOUT_MAX-1:0] res_vec;

	// Reload the bias copy only when the layer bank changes
	assign bias_stale = !bias_held || (bias_bank != bank);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			bias_held <= 1'b0;
			bias_bank <= 1'b0;
		end else if (bias_stale) begin
			bias_held <= 1'b1;
			bias_bank <= bank;
		end
	end

	always_ff @(posedge clk) begin
		if (bias_stale) begin
			bias_q <= bias;
		end
	end

	//////////////////////////////////////////////////
	// Requantization
	//////////////////////////////////////////////////
	always_comb begin
		conv_pkg::acc_t sum;
		conv_pkg::acc_t shifted;
		res_vec = '0;
		for (int k = 0; k < CHOUT; k++) begin
			sum     = acc[k] + conv_pkg::acc_t'(bias_q[k]);
			shifted = sum >>> conv_pkg::FRAC_BITS;
			if (sum < 0) begin
				res_vec[k] = '0;
			end else if (shifted > conv_pkg::OUT_MAX) begin
				res_vec[k] = conv_pkg::res_t'(conv_pkg::OUT_MAX);
			end else begin
				res_vec[k] = shifted[conv_pkg::RES_W-1:0];
			end
		end
	end

	// Empty, or emptied by this cycle's handshake
	assign slot_free = !out_valid || out_ready;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			out_valid <= 1'b0;
		end else if (cap_en) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (cap_en) begin
			out_data.res     <= res_vec;
			out_data.pix_idx <= pix_idx;
		end
	end

endmodule

`default_nettype wire

/* hdl/expand_ctrl.sv */
// Sequencer for layer, pixel and channel counts with stream handshakes and done

`timescale 1ns/1ns
`default_nettype none

module expand_ctrl #(
	parameter int CHIN       = 16,
	parameter int NUM_PIXELS = 16
) (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     start,
	input  wire                     layer_sel,
	input  wire                     in_valid,
	input  wire                     in_last,
	output logic                    in_ready,
	input  wire                     slot_free,
	input  wire                     out_fire,
	output logic [$clog2(CHIN)-1:0] chan_idx,
	output logic                    bank,
	output logic                    acc_en,
	output logic                    acc_load,
	output logic                    cap_en,
	output conv_pkg::pix_t          pix_idx,
	output logic                    busy,
	output logic                    done
);

	conv_pkg::ctrl_state_t   state;
	logic [$clog2(CHIN)-1:0] chan_cnt;
	conv_pkg::pix_t          feed_cnt;
	conv_pkg::pix_t          cap_cnt;
	logic                    feed_done;
	logic                    pending;
	logic                    start_ok;
	logic                    in_fire;
	logic                    last_chan;

	//////////////////////////////////////////////////
	// Handshake terms
	//////////////////////////////////////////////////
	assign start_ok  = start && !busy;
	assign last_chan = (chan_cnt == CHIN - 1);

	// Hold input while finished sums wait for a full output slot
	assign in_ready = (state == conv_pkg::RUN) && !feed_done && (!pending || slot_free);
	assign in_fire  = in_valid && in_ready;

	assign acc_en   = in_fire;
	assign acc_load = (chan_cnt == '0);
	assign cap_en   = pending && slot_free;
	assign chan_idx = chan_cnt;
	assign pix_idx  = cap_cnt;

	// Stays up through the done cycle
	assign busy = (state != conv_pkg::IDLE) || done;

	//////////////////////////////////////////////////
	// Layer FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= conv_pkg::IDLE;
			bank  <= 1'b0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				conv_pkg::IDLE: begin
					if (start_ok) begin
						state <= conv_pkg::RUN;
						bank  <= layer_sel;
					end
				end
				conv_pkg::RUN: begin
					// Last pixel moves into the output register
					if (cap_en && (cap_cnt == NUM_PIXELS - 1)) begin
						state <= conv_pkg::DRAIN;
					end
				end
				conv_pkg::DRAIN: begin
					if (out_fire) begin
						state <= conv_pkg::IDLE;
						done  <= 1'b1;
					end
				end
				default: state <= conv_pkg::IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Channel and pixel counters
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			chan_cnt  <= '0;
			feed_cnt  <= '0;
			feed_done <= 1'b0;
		end else if (start_ok) begin
			chan_cnt  <= '0;
			feed_cnt  <= '0;
			feed_done <= 1'b0;
		end else if (in_fire) begin
			if (last_chan) begin
				chan_cnt <= '0;
				if (feed_cnt == NUM_PIXELS - 1) begin
					feed_done <= 1'b1;
				end else begin
					feed_cnt <= feed_cnt + 1'b1;
				end
			end else begin
				chan_cnt <= chan_cnt + 1'b1;
			end
		end
	end

	// Index of the next pixel to be captured
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cap_cnt <= '0;
		end else if (start_ok) begin
			cap_cnt <= '0;
		end else if (cap_en) begin
			cap_cnt <= cap_cnt + 1'b1;
		end
	end

	// Finished sums not yet captured
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pending <= 1'b0;
		end else begin
			pending <= (pending && !cap_en) || (in_fire && last_chan);
		end
	end

endmodule

`default_nettype wire

/* hdl/expand_1x1_top.sv */
// Top level of the 1x1 expand convolution engine

`timescale 1ns/1ns
`default_nettype none

module expand_1x1_top #(
	parameter int CHIN       = 16,
	parameter int CHOUT      = 8,
	parameter int NUM_PIXELS = 16
) (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     start,
	input  wire                     layer_sel,
	input  wire                     in_valid,
	output logic                    in_ready,
	input  wire conv_pkg::in_beat_t in_data,
	output logic                    out_valid,
	input  wire                     out_ready,
	output conv_pkg::out_beat_t     out_data,
	output logic                    busy,
	output logic                    done
);

	logic [$clog2(CHIN)-1:0]     chan_idx;
	logic                        bank;
	logic                        acc_en;
	logic                        acc_load;
	logic                        cap_en;
	logic                        slot_free;
	logic                        out_fire;
	conv_pkg::pix_t              pix_idx;
	conv_pkg::wgt_t  [CHOUT-1:0] wgt;
	conv_pkg::bias_t [CHOUT-1:0] bias;
	conv_pkg::acc_t  [CHOUT-1:0] acc;

	assign out_fire = out_valid && out_ready;

	expand_ctrl #(
		.CHIN       (CHIN),
		.NUM_PIXELS (NUM_PIXELS)
	) u_ctrl (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.layer_sel (layer_sel),
		.in_valid  (in_valid),
		.in_last   (in_data.last),
		.in_ready  (in_ready),
		.slot_free (slot_free),
		.out_fire  (out_fire),
		.chan_idx  (chan_idx),
		.bank      (bank),
		.acc_en    (acc_en),
		.acc_load  (acc_load),
		.cap_en    (cap_en),
		.pix_idx   (pix_idx),
		.busy      (busy),
		.done      (done)
	);

	coef_rom #(.CHIN(CHIN), .CHOUT(CHOUT)) u_rom (
		.bank     (bank),
		.chan_idx (chan_idx),
		.wgt      (wgt),
		.bias     (bias)
	);

	mac_array #(.CHOUT(CHOUT)) u_mac (
		.clk      (clk),
		.rst      (rst),
		.acc_en   (acc_en),
		.acc_load (acc_load),
		.act      (in_data.act),
		.wgt      (wgt),
		.acc      (acc)
	);

	requant_relu #(.CHOUT(CHOUT)) u_requant (
		.clk       (clk),
		.rst       (rst),
		.cap_en    (cap_en),
		.bank      (bank),
		.acc       (acc),
		.bias      (bias),
		.pix_idx   (pix_idx),
		.out_ready (out_ready),
		.out_valid (out_valid),
		.out_data  (out_data),
		.slot_free (slot_free)
	);

endmodule

`default_nettype wire

/* bench/expand_checker.sv */
// Bound assertions on the stream handshakes and done pulse of the expand engine

`timescale 1ns/1ns
`default_nettype none

module expand_checker #(
	parameter int CHIN = 16
) (
	input wire                      clk,
	input wire                      rst,
	input wire                      in_valid,
	input wire                      in_ready,
	input wire conv_pkg::in_beat_t  in_data,
	input wire                      out_valid,
	input wire                      out_ready,
	input wire conv_pkg::out_beat_t out_data,
	input wire                      done
);

	localparam int CHAN_W = $clog2(CHIN);

	logic [CHAN_W-1:0] chan_cnt;
	int                fail_cnt = 0;

	// Position of the next input beat within its pixel
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			chan_cnt <= '0;
		end else if (in_valid && in_ready) begin
			if (chan_cnt == CHAN_W'(CHIN - 1)) begin
				chan_cnt <= '0;
			end else begin
				chan_cnt <= chan_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Properties
	//////////////////////////////////////////////////
	out_hold: assert property (@(posedge clk) disable iff (!rst)
		out_valid && !out_ready |=> $stable(out_data))
		else begin
			fail_cnt++;
			$error("out_data changed while stalled");
		end

	done_pulse: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
		else begin
			fail_cnt++;
			$error("done held longer than one cycle");
		end

	reset_quiet: assert property (@(posedge clk) !rst |-> !in_ready && !out_valid)
		else begin
			fail_cnt++;
			$error("stream handshake active in reset");
		end

	last_framing: assert property (@(posedge clk) disable iff (!rst)
		in_valid && in_ready |-> (in_data.last == (chan_cnt == CHAN_W'(CHIN - 1))))
		else begin
			fail_cnt++;
			$error("in_data.last disagrees with the channel count");
		end

endmodule

bind expand_1x1_top expand_checker #(.CHIN(CHIN)) u_checker (
	.clk       (clk),
	.rst       (rst),
	.in_valid  (in_valid),
	.in_ready  (in_ready),
	.in_data   (in_data),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_data  (out_data),
	.done      (done)
);

`default_nettype wire

/* bench/expand_tb.sv */
// Testbench for the 1x1 expand engine running directed layer tests against a reference model

`timescale 1ns/1ns
`default_nettype none

module expand_tb;

	localparam int CHIN        = 16;
	localparam int CHOUT       = 8;
	localparam int NUM_PIXELS  = 16;
	localparam int NUM_LAYERS  = 6;
	localparam int TOTAL_BEATS = NUM_LAYERS * NUM_PIXELS * CHIN;
	localparam int TIMEOUT_NS  = TOTAL_BEATS * 8 * 4 + 20000;

	logic                clk;
	logic                rst;
	logic                start;
	logic                layer_sel;
	logic                in_valid;
	logic                in_ready;
	conv_pkg::in_beat_t  in_data;
	logic                out_valid;
	logic                out_ready;
	conv_pkg::out_beat_t out_data;
	logic                busy;
	logic                done;

	int   seed;
	int   err_cnt;
	int   chk_cnt;
	int   act_mem [NUM_PIXELS][CHIN];
	logic stall_mode;
	logic hold_seen;

	expand_1x1_top #(
		.CHIN       (CHIN),
		.CHOUT      (CHOUT),
		.NUM_PIXELS (NUM_PIXELS)
	) DUT (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.layer_sel (layer_sel),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data),
		.busy      (busy),
		.done      (done)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("TEST FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////
	function automatic int weight_of(input int layer, input int k, input int c);
		return (((5 * k + 3 * c + 11 * layer) % 32) - 16) * 256;
	endfunction

	function automatic int bias_of(input int layer, input int k);
		return ((k % 8) - 4 + 2 * layer) * 32768;
	endfunction

	function automatic conv_pkg::res_t expected_res(input int layer, input int k, input int pix);
		longint sum;
		longint scaled;
		sum = longint'(bias_of(layer, k));
		for (int c = 0; c < CHIN; c++) begin
			sum += longint'(act_mem[pix][c]) * longint'(weight_of(layer, k, c));
		end
		// ReLU before the shift
		if (sum < 0) begin
			return '0;
		end
		scaled = sum >>> conv_pkg::FRAC_BITS;
		if (scaled > conv_pkg::OUT_MAX) begin
			return conv_pkg::res_t'(conv_pkg::OUT_MAX);
		end
		return conv_pkg::res_t'(scaled);
	endfunction

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////
	task automatic check_res(input int pix, input int k,
			input conv_pkg::res_t got, input conv_pkg::res_t exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("MISMATCH %0t ns: pixel %0d channel %0d gave %0d, expected %0d",
				$time, pix, k, got, exp);
		end
	endtask

	task automatic check_pix(input conv_pkg::pix_t got, input conv_pkg::pix_t exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("MISMATCH %0t ns: pixel index %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("MISMATCH %0t ns: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// Stream drivers
	//////////////////////////////////////////////////

	// All tasks begin and end 1 ns after a rising edge
	task automatic start_layer(input int layer);
		start     = 1'b1;
		layer_sel = layer[0];
		@(posedge clk);
		#1;
		start = 1'b0;
		@(negedge clk);
		check_flag("busy after start", busy, 1'b1);
		@(posedge clk);
		#1;
	endtask

	task automatic feed_layer();
		for (int p = 0; p < NUM_PIXELS; p++) begin
			for (int c = 0; c < CHIN; c++) begin
				in_valid     = 1'b1;
				in_data.act  = conv_pkg::act_t'(act_mem[p][c]);
				in_data.last = (c == CHIN - 1);
				do begin
					@(negedge clk);
					// Finished sums blocked by a full output register
					if (!in_ready && out_valid && !out_ready) begin
						hold_seen = 1'b1;
					end
				end while (!in_ready);
				@(posedge clk);
				#1;
			end
		end
		in_valid = 1'b0;
	endtask

	task automatic collect_layer(input int layer);
		int got;
		int stall_cnt;
		int r;
		got       = 0;
		stall_cnt = 0;
		while (got < NUM_PIXELS) begin
			if (stall_mode && stall_cnt == 0) begin
				r = $random(seed);
				if (r[1:0] == 2'b00) begin
					stall_cnt = int'(r[7:2]);
				end
			end
			if (stall_cnt > 0) begin
				out_ready = 1'b0;
				stall_cnt--;
			end else begin
				out_ready = 1'b1;
			end
			@(negedge clk);
			check_flag("done before last output", done, 1'b0);
			if (out_valid && out_ready) begin
				check_pix(out_data.pix_idx, conv_pkg::pix_t'(got));
				for (int k = 0; k < CHOUT; k++) begin
					check_res(got, k, out_data.res[k], expected_res(layer, k, got));
				end
				got++;
			end
			@(posedge clk);
			#1;
		end
		out_ready = 1'b1;
		@(negedge clk);
		check_flag("done after last output", done, 1'b1);
		check_flag("busy during done", busy, 1'b1);
		@(posedge clk);
		#1;
		@(negedge clk);
		check_flag("done one cycle later", done, 1'b0);
		check_flag("busy after done", busy, 1'b0);
		@(posedge clk);
		#1;
	endtask

	task automatic run_layer(input int layer);
		fork
			feed_layer();
			collect_layer(layer);
		join
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////
	task automatic test_ramp_pixel();
		for (int p = 0; p < NUM_PIXELS; p++) begin
			for (int c = 0; c < CHIN; c++) begin
				act_mem[p][c] = 1000 * (c + 1);
			end
		end
		start_layer(0);
		run_layer(0);
	endtask

	task automatic test_random_layer();
		for (int p = 0; p < NUM_PIXELS; p++) begin
			for (int c = 0; c < CHIN; c++) begin
				act_mem[p][c] = $random(seed) & 32'h7fff;
			end
		end
		start_layer(1);
		run_layer(1);
	endtask

	// Odd pixels all zero and even pixels at full scale
	// Pixels 2, 6, 10 and 14 follow the weight signs of one lane to drive it into saturation
	task automatic test_extremes();
		int k;
		for (int p = 0; p < NUM_PIXELS; p++) begin
			k = (p / 4) % CHOUT;
			for (int c = 0; c < CHIN; c++) begin
				if (p % 2 == 1) begin
					act_mem[p][c] = 0;
				end else if (p % 4 == 0) begin
					act_mem[p][c] = 32767;
				end else if (weight_of(0, k, c) < 0) begin
					act_mem[p][c] = -32768;
				end else begin
					act_mem[p][c] = 32767;
				end
			end
		end
		start_layer(0);
		run_layer(0);
	endtask

	task automatic test_output_stalls();
		for (int p = 0; p < NUM_PIXELS; p++) begin
			for (int c = 0; c < CHIN; c++) begin
				act_mem[p][c] = int'(conv_pkg::act_t'($random(seed)));
			end
		end
		stall_mode = 1'b1;
		hold_seen  = 1'b0;
		start_layer(0);
		run_layer(0);
		stall_mode = 1'b0;
		check_flag("input held while output full", hold_seen, 1'b1);
	endtask

	task automatic test_busy_done();
		for (int p = 0; p < NUM_PIXELS; p++) begin
			for (int c = 0; c < CHIN; c++) begin
				act_mem[p][c] = $random(seed) & 32'h3fff;
			end
		end
		start_layer(0);
		// Second request while busy, other bank
		start     = 1'b1;
		layer_sel = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		@(negedge clk);
		check_flag("busy after ignored start", busy, 1'b1);
		@(posedge clk);
		#1;
		run_layer(0);
		start_layer(1);
		run_layer(1);
	endtask

	initial begin
		seed       = 32'h536b;
		err_cnt    = 0;
		chk_cnt    = 0;
		rst        = 1'b0;
		start      = 1'b0;
		layer_sel  = 1'b0;
		in_valid   = 1'b0;
		in_data    = '0;
		out_ready  = 1'b1;
		stall_mode = 1'b0;
		hold_seen  = 1'b0;
		repeat (7) @(posedge clk);
		@(negedge clk);
		check_flag("in_ready in reset", in_ready, 1'b0);
		check_flag("out_valid in reset", out_valid, 1'b0);
		check_flag("busy in reset", busy, 1'b0);
		check_flag("done in reset", done, 1'b0);
		@(posedge clk);
		#1;
		rst = 1'b1;
		@(posedge clk);
		#1;
		test_ramp_pixel();
		test_random_layer();
		test_extremes();
		test_output_stalls();
		test_busy_done();
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			chk_cnt, err_cnt, DUT.u_checker.fail_cnt);
		if (err_cnt == 0 && DUT.u_checker.fail_cnt == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
hdl/conv_pkg.sv
hdl/coef_rom.sv
hdl/mac_array.sv
hdl/requant_relu.sv
hdl/expand_ctrl.sv
hdl/expand_1x1_top.sv
bench/expand_checker.sv
bench/expand_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the expand engine testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module expand_tb -o expand_sim \
	&& ./obj_dir/expand_sim | tee /dev/stderr | grep -qx "TEST OK" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
